// ==== all.f ====
+incdir+source
source/isaPkg.sv
source/pipePkg.sv
source/creditFifo.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/riscCore.sv
bench/riscCoreTb.sv

// ==== bench/riscCoreTb.sv ====
// Table-driven testbench for the core that loads each program slice, runs it and checks write-backs
`timescale 1ns/100ps
`include "core_defines.svh"

module riscCoreTb;

   localparam int TEST_COUNT = 6;
   localparam int RANDOM_OPS = 20;

   logic                    Clock;
   logic                    rstN;
   logic                    progWrite;
   logic [`PC_BITS-1:0]     progAddr;
   isaPkg::instrT           progData;
   logic                    run;
   logic                    wbValid;
   logic [`REG_BITS-1:0]    wbReg;
   logic [`DATA_WIDTH-1:0]  wbData;
   logic                    halted;

   // Program table where each test is a slice ending in HALT
   isaPkg::instrT           progTable [$];
   int                      testStart [TEST_COUNT];
   int                      testLen [TEST_COUNT];
   string                   testName [TEST_COUNT];
   logic [`DATA_WIDTH-1:0]  modelRegs [`REG_COUNT];
   logic [`REG_BITS-1:0]    expReg [$];
   logic [`DATA_WIDTH-1:0]  expData [$];
   logic [31:0]             lcgState = 32'h25cf_a0ad;
   int                      errorCount = 0;
   bit                      tableReady = 1'b0;

   riscCore u_riscCore (
      .Clock     (Clock),
      .rstN      (rstN),
      .progWrite (progWrite),
      .progAddr  (progAddr),
      .progData  (progData),
      .run       (run),
      .wbValid   (wbValid),
      .wbReg     (wbReg),
      .wbData    (wbData),
      .halted    (halted)
   );

   initial begin
      Clock = 1'b0;
      forever #10 Clock = ~Clock;
   end

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   function automatic isaPkg::instrT regOp(isaPkg::opcodeT op, logic [3:0] ra,
                                           logic [3:0] rb, logic [3:0] rc);
      isaPkg::instrT word;
      word.opcode = op;
      word.ra     = ra;
      word.rb     = rb;
      word.imm    = {rc, 15'd0};
      return word;
   endfunction

   function automatic isaPkg::instrT immOp(isaPkg::opcodeT op, logic [3:0] ra,
                                           logic [3:0] rb, logic [18:0] imm);
      isaPkg::instrT word;
      word.opcode = op;
      word.ra     = ra;
      word.rb     = rb;
      word.imm    = imm;
      return word;
   endfunction

   // Random register or immediate op on any register including r0
   function automatic isaPkg::instrT randomOp();
      logic [31:0]    pick;
      logic [31:0]    fields;
      isaPkg::opcodeT op;
      pick   = nextRand();
      fields = nextRand();
      case (pick % 32'd7)
         0:       op = isaPkg::ADD;
         1:       op = isaPkg::SUB;
         2:       op = isaPkg::AND;
         3:       op = isaPkg::OR;
         4:       op = isaPkg::ADDI;
         5:       op = isaPkg::ANDI;
         default: op = isaPkg::ORI;
      endcase
      if (op inside {isaPkg::ADDI, isaPkg::ANDI, isaPkg::ORI}) begin
         return immOp(op, fields[31:28], fields[27:24], fields[30:12]);
      end
      return regOp(op, fields[31:28], fields[27:24], fields[23:20]);
   endfunction

   task automatic beginTest(input int idx, input string name);
      testStart[idx] = progTable.size();
      testName[idx]  = name;
   endtask

   task automatic endTest(input int idx);
      progTable.push_back(regOp(isaPkg::HALT, 0, 0, 0));
      testLen[idx] = progTable.size() - testStart[idx];
   endtask

   task automatic buildTable();
      beginTest(0, "immediate ops and sign extension");
      progTable.push_back(immOp(isaPkg::ADDI, 4, 0, 19'h005A5));
      progTable.push_back(immOp(isaPkg::ANDI, 2, 4, 19'h000F0));
      progTable.push_back(immOp(isaPkg::ORI, 6, 4, 19'h70000));
      progTable.push_back(immOp(isaPkg::ADDI, 7, 4, 19'h7FFFD));
      progTable.push_back(immOp(isaPkg::ANDI, 8, 4, 19'h7FF0F));
      endTest(0);
      beginTest(1, "dependent register chains");
      progTable.push_back(immOp(isaPkg::ADDI, 1, 0, 19'd100));
      progTable.push_back(immOp(isaPkg::ADDI, 2, 0, 19'd37));
      progTable.push_back(regOp(isaPkg::ADD, 3, 1, 2));
      progTable.push_back(regOp(isaPkg::SUB, 4, 3, 2));
      progTable.push_back(regOp(isaPkg::AND, 5, 4, 3));
      progTable.push_back(regOp(isaPkg::OR, 6, 5, 1));
      progTable.push_back(regOp(isaPkg::SUB, 7, 0, 6));
      endTest(1);
      beginTest(2, "multiply ordering");
      progTable.push_back(immOp(isaPkg::ADDI, 1, 0, 19'h12345));
      progTable.push_back(immOp(isaPkg::ADDI, 2, 0, 19'h7FFB3));
      progTable.push_back(regOp(isaPkg::MUL, 3, 1, 2));
      progTable.push_back(immOp(isaPkg::ADDI, 4, 0, 19'd9));
      progTable.push_back(regOp(isaPkg::ADD, 5, 1, 1));
      progTable.push_back(regOp(isaPkg::MUL, 6, 3, 1));
      progTable.push_back(regOp(isaPkg::SUB, 7, 4, 5));
      endTest(2);
      beginTest(3, "writes to r0");
      progTable.push_back(immOp(isaPkg::ADDI, 0, 0, 19'd55));
      progTable.push_back(immOp(isaPkg::ADDI, 1, 0, 19'd11));
      progTable.push_back(regOp(isaPkg::ADD, 0, 1, 1));
      progTable.push_back(immOp(isaPkg::ORI, 2, 0, 19'd4));
      progTable.push_back(regOp(isaPkg::ADD, 3, 0, 1));
      endTest(3);
      beginTest(4, "random stream");
      for (int n = 0; n < RANDOM_OPS; n++) begin
         progTable.push_back(randomOp());
      end
      endTest(4);
      // Reads r1 and r5 before writing them, so stale registers would show
      beginTest(5, "reset and rerun");
      progTable.push_back(immOp(isaPkg::ADDI, 1, 1, 19'd5));
      progTable.push_back(immOp(isaPkg::ADDI, 1, 1, 19'd7));
      progTable.push_back(regOp(isaPkg::MUL, 3, 1, 1));
      progTable.push_back(regOp(isaPkg::ADD, 5, 5, 3));
      progTable.push_back(regOp(isaPkg::SUB, 6, 3, 1));
      endTest(5);
   endtask

   // Expected write-backs in program order from a zeroed register file
   task automatic modelSlice(input int idx);
      isaPkg::instrT          w;
      logic [`DATA_WIDTH-1:0] a;
      logic [`DATA_WIDTH-1:0] b;
      logic [`DATA_WIDTH-1:0] ext;
      logic [`DATA_WIDTH-1:0] result;
      logic                   writes;
      expReg.delete();
      expData.delete();
      for (int i = 0; i < `REG_COUNT; i++) begin
         modelRegs[i] = '0;
      end
      for (int n = 0; n < testLen[idx]; n++) begin
         w      = progTable[testStart[idx] + n];
         a      = modelRegs[w.rb];
         b      = modelRegs[w.imm[18:15]];
         ext    = $signed(w.imm);
         writes = 1'b1;
         case (w.opcode)
            isaPkg::ADD:  result = a + b;
            isaPkg::SUB:  result = a - b;
            isaPkg::AND:  result = a & b;
            isaPkg::OR:   result = a | b;
            isaPkg::ADDI: result = a + ext;
            isaPkg::ANDI: result = a & ext;
            isaPkg::ORI:  result = a | ext;
            isaPkg::MUL:  result = a * b;
            default: begin
               result = '0;
               writes = 1'b0;
            end
         endcase
         if (writes && (w.ra != 0)) begin
            modelRegs[w.ra] = result;
            expReg.push_back(w.ra);
            expData.push_back(result);
         end
      end
   endtask

   task automatic reportFailure(input string msg);
      $display("Failure at %0t: %s", $time, msg);
      errorCount++;
   endtask

   task automatic checkReg(input logic [`REG_BITS-1:0] expected,
                           input logic [`REG_BITS-1:0] actual);
      if (actual !== expected) begin
         $display("** Error at %0t: wbReg expected %0d, got %0d", $time, expected, actual);
         errorCount++;
      end
   endtask

   task automatic checkData(input logic [`DATA_WIDTH-1:0] expected,
                            input logic [`DATA_WIDTH-1:0] actual);
      if (actual !== expected) begin
         $display("** Error at %0t: wbData expected %h, got %h", $time, expected, actual);
         errorCount++;
      end
   endtask

   task automatic resetCore();
      @(posedge Clock);
      #2;
      rstN      = 1'b0;
      run       = 1'b0;
      progWrite = 1'b0;
      repeat (3) @(posedge Clock);
      #2;
      rstN = 1'b1;
   endtask

   task automatic loadSlice(input int idx);
      for (int n = 0; n < testLen[idx]; n++) begin
         @(posedge Clock);
         #2;
         progWrite = 1'b1;
         progAddr  = n[`PC_BITS-1:0];
         progData  = progTable[testStart[idx] + n];
         @(negedge Clock);
         if (wbValid) begin
            reportFailure("write-back while the core was idle");
         end
         if (halted) begin
            reportFailure("halted still high after reset");
         end
      end
   endtask

   task automatic pulseRun();
      @(posedge Clock);
      #2;
      progWrite = 1'b0;
      run       = 1'b1;
      @(posedge Clock);
      #2;
      run = 1'b0;
   endtask

   // Sampled at the falling edge, where the registered outputs are settled
   task automatic collectWriteBacks(output int seen);
      seen = 0;
      do begin
         @(negedge Clock);
         if (wbValid) begin
            seen++;
            if (expReg.size() == 0) begin
               reportFailure($sformatf("unexpected extra write-back to r%0d", wbReg));
            end else begin
               checkReg(expReg.pop_front(), wbReg);
               checkData(expData.pop_front(), wbData);
            end
         end
      end while (!halted);
      repeat (5) begin
         @(negedge Clock);
         if (wbValid) begin
            reportFailure("write-back after halted rose");
         end
         if (!halted) begin
            reportFailure("halted fell before reset");
         end
      end
      if (expReg.size() != 0) begin
         reportFailure($sformatf("%0d write-backs missing at halt", expReg.size()));
      end
   endtask

   // Starts a run and leaves it at its first write-back while later ops are still in flight
   task automatic abortedRun(input int idx);
      resetCore();
      loadSlice(idx);
      pulseRun();
      do begin
         @(negedge Clock);
      end while (!wbValid);
   endtask

   task automatic runTest(input int idx);
      int errorsBefore;
      int seen;
      errorsBefore = errorCount;
      resetCore();
      modelSlice(idx);
      loadSlice(idx);
      pulseRun();
      collectWriteBacks(seen);
      $display("Test %0d (%s): %0d write-backs, %0d errors",
               idx + 1, testName[idx], seen, errorCount - errorsBefore);
   endtask

   initial begin
      rstN      = 1'b0;
      progWrite = 1'b0;
      progAddr  = '0;
      progData  = '0;
      run       = 1'b0;
      buildTable();
      tableReady = 1'b1;
      for (int t = 0; t < TEST_COUNT; t++) begin
         if (t == TEST_COUNT - 1) begin
            abortedRun(t);
         end
         runTest(t);
      end
      $display("Summary: %0d tests run, %0d errors", TEST_COUNT, errorCount);
      if (errorCount == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   // Last test runs its slice twice
   initial begin
      int limit;
      wait (tableReady);
      limit = (progTable.size() + testLen[TEST_COUNT - 1]) * 40 + 200;
      repeat (limit) @(posedge Clock);
      $display("Watchdog expired after %0d cycles, the run did not finish", limit);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// ==== source/riscCore.sv ====
// Top level of the core: fetch, decode and execute joined by credit links
`timescale 1ns/100ps
`include "core_defines.svh"

module riscCore (
   input  logic                    Clock,
   input  logic                    rstN,
   input  logic                    progWrite,
   input  logic [`PC_BITS-1:0]     progAddr,
   input  isaPkg::instrT           progData,
   input  logic                    run,
   output logic                    wbValid,
   output logic [`REG_BITS-1:0]    wbReg,
   output logic [`DATA_WIDTH-1:0]  wbData,
   output logic                    halted
);

   // Fetch to decode link
   logic                  fetchValid;
   pipePkg::fetchPacketT  fetchPacket;
   logic                  fetchCredit;

   // Decode to execute link
   logic                  issueValid;
   pipePkg::issuePacketT  issuePacket;
   logic                  issueCredit;

   fetchStage u_fetchStage (
      .Clock        (Clock),
      .rstN         (rstN),
      .progWrite    (progWrite),
      .progAddr     (progAddr),
      .progData     (progData),
      .run          (run),
      .outValid     (fetchValid),
      .outPacket    (fetchPacket),
      .creditReturn (fetchCredit)
   );

   // Write-back also feeds the register file and scoreboard
   decodeStage u_decodeStage (
      .Clock     (Clock),
      .rstN      (rstN),
      .inValid   (fetchValid),
      .inPacket  (fetchPacket),
      .inCredit  (fetchCredit),
      .outValid  (issueValid),
      .outPacket (issuePacket),
      .outCredit (issueCredit),
      .wbValid   (wbValid),
      .wbReg     (wbReg),
      .wbData    (wbData)
   );

   executeStage u_executeStage (
      .Clock    (Clock),
      .rstN     (rstN),
      .inValid  (issueValid),
      .inPacket (issuePacket),
      .inCredit (issueCredit),
      .wbValid  (wbValid),
      .wbReg    (wbReg),
      .wbData   (wbData),
      .halted   (halted)
   );

endmodule

// ==== source/executeStage.sv ====
// Execute stage: single-cycle ALU, iterative multiplier and in-order write-back
`timescale 1ns/100ps
`include "core_defines.svh"

module executeStage (
   input  logic                    Clock,
   input  logic                    rstN,
   input  logic                    inValid,
   input  pipePkg::issuePacketT    inPacket,
   output logic                    inCredit,
   output logic                    wbValid,
   output logic [`REG_BITS-1:0]    wbReg,
   output logic [`DATA_WIDTH-1:0]  wbData,
   output logic                    halted
);

   localparam int STEP_BITS = $clog2(`DATA_WIDTH);

   logic                    headValid;
   pipePkg::issuePacketT    head;
   logic                    isMul;
   logic                    mulBusy;
   logic                    mulStart;
   logic                    mulFinish;
   logic [STEP_BITS-1:0]    mulStep;
   logic [`DATA_WIDTH-1:0]  mulCand;
   logic [`DATA_WIDTH-1:0]  mulPlier;
   logic [`DATA_WIDTH-1:0]  mulAcc;
   logic [`DATA_WIDTH-1:0]  mulNext;
   logic [`DATA_WIDTH-1:0]  aluResult;
   logic                    pop;

   creditFifo #(.payloadT(pipePkg::issuePacketT)) u_inBuffer (
      .Clock        (Clock),
      .rstN         (rstN),
      .pushValid    (inValid),
      .pushData     (inPacket),
      .pop          (pop),
      .headValid    (headValid),
      .headData     (head),
      .creditReturn (inCredit)
   );

   assign isMul     = (head.opcode == isaPkg::MUL);
   assign mulStart  = headValid && isMul && !mulBusy;
   assign mulFinish = mulBusy && (mulStep == STEP_BITS'(`DATA_WIDTH - 1));
   // MUL holds the head until its last bit, so later ops wait behind it
   assign pop       = (headValid && !isMul) || mulFinish;

   // Add the shifted multiplicand when the current multiplier bit is set
   assign mulNext = mulPlier[0] ? (mulAcc + mulCand) : mulAcc;

   always_comb begin
      case (head.opcode)
         isaPkg::ADD, isaPkg::ADDI: aluResult = head.operandA + head.operandB;
         isaPkg::SUB:               aluResult = head.operandA - head.operandB;
         isaPkg::AND, isaPkg::ANDI: aluResult = head.operandA & head.operandB;
         isaPkg::OR, isaPkg::ORI:   aluResult = head.operandA | head.operandB;
         default:                   aluResult = '0;
      endcase
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         mulBusy <= 1'b0;
         mulStep <= '0;
         wbValid <= 1'b0;
         halted  <= 1'b0;
      end else begin
         wbValid <= pop && head.writeEn;
         if (mulStart) begin
            mulBusy <= 1'b1;
            mulStep <= '0;
         end else if (mulFinish) begin
            mulBusy <= 1'b0;
         end else if (mulBusy) begin
            mulStep <= mulStep + 1'b1;
         end
         // Earlier ops have all left the buffer by now
         if (pop && (head.opcode == isaPkg::HALT)) begin
            halted <= 1'b1;
         end
      end
   end

   always_ff @(posedge Clock) begin
      if (mulStart) begin
         mulCand  <= head.operandA;
         mulPlier <= head.operandB;
         mulAcc   <= '0;
      end else if (mulBusy) begin
         mulCand  <= mulCand << 1;
         mulPlier <= mulPlier >> 1;
         mulAcc   <= mulNext;
      end
      if (pop) begin
         wbReg  <= head.dest;
         wbData <= isMul ? mulNext : aluResult;
      end
   end

endmodule

// ==== source/decodeStage.sv ====
// Decode stage: register file, pending-write scoreboard, operand read and issue to execute
`timescale 1ns/100ps
`include "core_defines.svh"

module decodeStage (
   input  logic                    Clock,
   input  logic                    rstN,
   input  logic                    inValid,
   input  pipePkg::fetchPacketT    inPacket,
   output logic                    inCredit,
   output logic                    outValid,
   output pipePkg::issuePacketT    outPacket,
   input  logic                    outCredit,
   input  logic                    wbValid,
   input  logic [`REG_BITS-1:0]    wbReg,
   input  logic [`DATA_WIDTH-1:0]  wbData
);

   localparam int CREDIT_BITS = $clog2(`BUFFER_DEPTH + 1);

   logic [`DATA_WIDTH-1:0]  regFile [`REG_COUNT];
   logic [`REG_COUNT-1:0]   pending;
   logic [CREDIT_BITS-1:0]  credits;
   logic                    headValid;
   pipePkg::fetchPacketT    head;
   isaPkg::instrT           instr;
   logic [`REG_BITS-1:0]    rc;
   logic                    needRb;
   logic                    needRc;
   logic                    writeEn;
   logic                    hazard;
   logic                    issue;
   logic [`DATA_WIDTH-1:0]  srcA;
   logic [`DATA_WIDTH-1:0]  srcB;

   creditFifo #(.payloadT(pipePkg::fetchPacketT)) u_inBuffer (
      .Clock        (Clock),
      .rstN         (rstN),
      .pushValid    (inValid),
      .pushData     (inPacket),
      .pop          (issue),
      .headValid    (headValid),
      .headData     (head),
      .creditReturn (inCredit)
   );

   assign instr   = head.instr;
   assign rc      = isaPkg::rcOf(instr);
   assign needRb  = isaPkg::hasDest(instr.opcode);
   assign needRc  = isaPkg::usesRc(instr.opcode);
   // Results aimed at r0 are dropped
   assign writeEn = needRb && (instr.ra != '0);

   // A pending destination also stalls, so each write-back clears the bit of its own write
   assign hazard = (needRb && pending[instr.rb])
                 || (needRc && pending[rc])
                 || (writeEn && pending[instr.ra]);
   assign issue  = headValid && (credits != '0) && !hazard;

   // regFile[0] is never written and stays zero
   assign srcA = regFile[instr.rb];
   assign srcB = isaPkg::isImmediate(instr.opcode) ? isaPkg::immExt(instr) : regFile[rc];

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         outValid <= 1'b0;
         credits  <= CREDIT_BITS'(`BUFFER_DEPTH);
         pending  <= '0;
         for (int i = 0; i < `REG_COUNT; i++) begin
            regFile[i] <= '0;
         end
      end else begin
         outValid <= issue;
         credits  <= credits - CREDIT_BITS'(issue) + CREDIT_BITS'(outCredit);
         if (wbValid && (wbReg != '0)) begin
            regFile[wbReg] <= wbData;
         end
         // Never the same register, the destination stall sees to that
         if (wbValid) begin
            pending[wbReg] <= 1'b0;
         end
         if (issue && writeEn) begin
            pending[instr.ra] <= 1'b1;
         end
      end
   end

   always_ff @(posedge Clock) begin
      if (issue) begin
         outPacket.opcode   <= instr.opcode;
         outPacket.dest     <= instr.ra;
         outPacket.writeEn  <= writeEn;
         outPacket.operandA <= srcA;
         outPacket.operandB <= srcB;
      end
   end

endmodule

// ==== source/fetchStage.sv ====
// Fetch stage: program memory, PC and the credit counter toward decode
`timescale 1ns/100ps
`include "core_defines.svh"

module fetchStage (
   input  logic                  Clock,
   input  logic                  rstN,
   input  logic                  progWrite,
   input  logic [`PC_BITS-1:0]   progAddr,
   input  isaPkg::instrT         progData,
   input  logic                  run,
   output logic                  outValid,
   output pipePkg::fetchPacketT  outPacket,
   input  logic                  creditReturn
);

   localparam int CREDIT_BITS = $clog2(`BUFFER_DEPTH + 1);

   isaPkg::instrT           progMem [`IMEM_DEPTH];
   logic [`PC_BITS-1:0]     pc;
   logic                    running;
   logic [CREDIT_BITS-1:0]  credits;
   isaPkg::instrT           curInstr;
   logic                    send;

   assign curInstr = progMem[pc];
   // One word per cycle while decode has room
   assign send     = running && (credits != '0);

   // Loaded while the core is idle
   always_ff @(posedge Clock) begin
      if (progWrite) begin
         progMem[progAddr] <= progData;
      end
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         pc       <= '0;
         running  <= 1'b0;
         outValid <= 1'b0;
         credits  <= CREDIT_BITS'(`BUFFER_DEPTH);
      end else begin
         outValid <= send;
         credits  <= credits - CREDIT_BITS'(send) + CREDIT_BITS'(creditReturn);
         if (run && !running) begin
            pc      <= '0;
            running <= 1'b1;
         end else if (send) begin
            pc <= pc + 1'b1;
            // Nothing past HALT is fetched
            if (curInstr.opcode == isaPkg::HALT) begin
               running <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge Clock) begin
      if (send) begin
         outPacket.instr <= curInstr;
         outPacket.pc    <= pc;
      end
   end

endmodule

// ==== source/creditFifo.sv ====
// Receive buffer at the end of a credit link; returns one credit for every entry it releases
`timescale 1ns/100ps
`include "core_defines.svh"

module creditFifo #(
   parameter type payloadT = logic [7:0]
) (
   input  logic    Clock,
   input  logic    rstN,
   input  logic    pushValid,
   input  payloadT pushData,
   input  logic    pop,
   output logic    headValid,
   output payloadT headData,
   output logic    creditReturn
);

   localparam int PTR_BITS = (`BUFFER_DEPTH > 1) ? $clog2(`BUFFER_DEPTH) : 1;
   localparam int CNT_BITS = $clog2(`BUFFER_DEPTH + 1);

   payloadT              entries [`BUFFER_DEPTH];
   logic [PTR_BITS-1:0]  wrPtr;
   logic [PTR_BITS-1:0]  rdPtr;
   logic [CNT_BITS-1:0]  count;
   logic                 doPop;

   // Wraps at any depth, not only powers of two
   function automatic logic [PTR_BITS-1:0] nextPtr(logic [PTR_BITS-1:0] ptr);
      if (ptr == PTR_BITS'(`BUFFER_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   assign headValid    = (count != '0);
   assign headData     = entries[rdPtr];
   // A pop on an empty buffer is ignored
   assign doPop        = pop && headValid;
   assign creditReturn = doPop;

   always_ff @(posedge Clock) begin
      if (pushValid) begin
         entries[wrPtr] <= pushData;
      end
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         wrPtr <= '0;
         rdPtr <= '0;
         count <= '0;
      end else begin
         if (pushValid) begin
            wrPtr <= nextPtr(wrPtr);
         end
         if (doPop) begin
            rdPtr <= nextPtr(rdPtr);
         end
         count <= count + CNT_BITS'(pushValid) - CNT_BITS'(doPop);
      end
   end

endmodule

// ==== source/pipePkg.sv ====
// Payload types carried on the fetch-to-decode and decode-to-execute links
`include "core_defines.svh"

package pipePkg;

   // Fetch to decode
   typedef struct packed {
      isaPkg::instrT        instr;
      logic [`PC_BITS-1:0]  pc;
   } fetchPacketT;

   // Decode to execute, operands already read and extended
   typedef struct packed {
      isaPkg::opcodeT          opcode;
      logic [`REG_BITS-1:0]    dest;
      logic                    writeEn;
      logic [`DATA_WIDTH-1:0]  operandA;
      logic [`DATA_WIDTH-1:0]  operandB;
   } issuePacketT;

endpackage

// ==== source/isaPkg.sv ====
// Instruction set description: opcodes, instruction layout and field helpers
`include "core_defines.svh"

package isaPkg;

   typedef enum logic [4:0] {
      ADD  = 5'd0,
      SUB  = 5'd1,
      AND  = 5'd2,
      OR   = 5'd3,
      ADDI = 5'd4,
      ANDI = 5'd5,
      ORI  = 5'd6,
      MUL  = 5'd7,
      NOP  = 5'd30,
      HALT = 5'd31
   } opcodeT;

   // Immediate overlays rc, which sits in the top four bits of imm
   typedef struct packed {
      opcodeT               opcode;
      logic [`REG_BITS-1:0] ra;
      logic [`REG_BITS-1:0] rb;
      logic [18:0]          imm;
   } instrT;

   function automatic logic [`REG_BITS-1:0] rcOf(instrT instr);
      return instr.imm[18:15];
   endfunction

   function automatic logic [`DATA_WIDTH-1:0] immExt(instrT instr);
      return {{(`DATA_WIDTH - 19){instr.imm[18]}}, instr.imm};
   endfunction

   function automatic logic isImmediate(opcodeT op);
      return op inside {ADDI, ANDI, ORI};
   endfunction

   // Ops that read rb and write ra
   function automatic logic hasDest(opcodeT op);
      return op inside {ADD, SUB, AND, OR, ADDI, ANDI, ORI, MUL};
   endfunction

   function automatic logic usesRc(opcodeT op);
      return op inside {ADD, SUB, AND, OR, MUL};
   endfunction

endpackage

// ==== source/core_defines.svh ====
// Sizing macros for the core, included by every RTL file that needs a width or depth
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Register and datapath width
`define DATA_WIDTH 32

// Register file, r0 always reads zero
`define REG_COUNT 16
`define REG_BITS 4

// Program memory words and address width
`define IMEM_DEPTH 64
`define PC_BITS 6

// Entries per receive buffer, also the credit count after reset
`define BUFFER_DEPTH 2

`endif
